/* include/taint_mul_defines.svh */
/*
 * Width macros shared by the taint-tracking multiplier RTL and testbench.
 * Include this file wherever an operand or counter width is needed.
 */

`ifndef TAINT_MUL_DEFINES_SVH
`define TAINT_MUL_DEFINES_SVH

// ====================
// Operand sizing
// ====================

// Bits per operand word, product is twice this
`define MUL_WIDTH 8

// Bit counter must reach MUL_WIDTH itself, so one bit wider than an index
`define MUL_CNT_WIDTH 4

`endif

/* verilog/taintMulPkg.sv */
/*
 * Types shared by the multiplier control FSM and its bound checker.
 * Import with a wildcard in the module header.
 */

package taintMulPkg;

    // ====================
    // Control FSM states
    // ====================

    // One add/skip step per multiplier bit, SHIFT always comes first
    typedef enum logic [2:0] {
        START = 3'd0,
        INIT  = 3'd1,
        SHIFT = 3'd2,
        NOP   = 3'd3,
        LOAD  = 3'd4,
        FINAL = 3'd5
    } ctrlState;

endpackage

/* verilog/mulCtrlIf.sv */
/*
 * Control and datapath link of the multiplier.
 * Every strobe travels with a taint bit that marks secret-dependent control.
 */

`include "taint_mul_defines.svh"

interface mulCtrlIf;

    // Datapath strobes and their taints
    logic rsLoad;
    logic rsLoadTaint;
    logic rsClear;
    logic rsClearTaint;
    logic rsShr;
    logic rsShrTaint;
    logic mrLoad;
    logic mrLoadTaint;
    logic mdLoad;
    logic mdLoadTaint;
    logic productDone;
    logic productDoneTaint;

    // Multiplier word seen by the FSM for branching
    logic [`MUL_WIDTH-1:0] multiplier;
    logic multiplierTaint;

    modport ctrl (
        output rsLoad, rsLoadTaint, rsClear, rsClearTaint, rsShr, rsShrTaint,
        output mrLoad, mrLoadTaint, mdLoad, mdLoadTaint,
        output productDone, productDoneTaint,
        input  multiplier, multiplierTaint
    );

    modport dp (
        input  rsLoad, rsLoadTaint, rsClear, rsClearTaint, rsShr, rsShrTaint,
        input  mrLoad, mrLoadTaint, mdLoad, mdLoadTaint,
        input  productDone, productDoneTaint,
        output multiplier, multiplierTaint
    );

endinterface

/* verilog/multiplierControl.sv */
/*
 * Shift-and-add control FSM with word-level taint on state and bit counter.
 * Drives the datapath strobes, each with a taint bit, through mulCtrlIf.
 */

`include "taint_mul_defines.svh"

module multiplierControl
    import taintMulPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic startTaint,
    input  logic resultPending,
    output logic inReady,
    mulCtrlIf.ctrl ctl
);

    ctrlState state;
    ctrlState nextState;
    logic [`MUL_CNT_WIDTH-1:0] bitCnt;
    logic cntDone;
    logic curBit;
    // Shared taint of state and counter, sticky until FINAL
    logic ctlTaint;
    logic strobeTaint;

    // ====================
    // Decode
    // ====================

    assign cntDone = (bitCnt == `MUL_CNT_WIDTH'(`MUL_WIDTH));
    // Index bits only, counter top bit is set just once the last step is done
    assign curBit = ctl.multiplier[bitCnt[`MUL_CNT_WIDTH-2:0]];

    // New job not accepted while the output register still holds a result
    assign inReady = (state == START) && !resultPending;

    // In START the only steering input is the start request
    assign strobeTaint = (state == START) ? startTaint : ctlTaint;

    always_comb begin
        nextState = state;
        case (state)
            START: begin
                if (start) begin
                    nextState = INIT;
                end
            end
            INIT: nextState = SHIFT;
            SHIFT: nextState = curBit ? LOAD : NOP;
            NOP, LOAD: nextState = cntDone ? FINAL : SHIFT;
            FINAL: nextState = START;
            default: nextState = START;
        endcase
    end

    // ====================
    // Strobes
    // ====================

    always_comb begin
        ctl.rsLoad = 1'b0;
        ctl.rsClear = 1'b0;
        ctl.rsShr = 1'b0;
        ctl.mrLoad = 1'b0;
        ctl.mdLoad = 1'b0;
        ctl.productDone = 1'b0;
        case (state)
            // Operands captured on the accepting edge
            START: begin
                ctl.mdLoad = start;
                ctl.mrLoad = start;
            end
            INIT: ctl.rsClear = 1'b1;
            SHIFT: ctl.rsShr = 1'b1;
            LOAD: ctl.rsLoad = 1'b1;
            FINAL: begin
                ctl.rsShr = 1'b1;
                ctl.productDone = 1'b1;
            end
            default: ;
        endcase
    end

    // Every strobe value depends on the state, so all share its taint
    assign ctl.rsLoadTaint = strobeTaint;
    assign ctl.rsClearTaint = strobeTaint;
    assign ctl.rsShrTaint = strobeTaint;
    assign ctl.mrLoadTaint = strobeTaint;
    assign ctl.mdLoadTaint = strobeTaint;
    assign ctl.productDoneTaint = strobeTaint;

    // ====================
    // State, counter, taint
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
            bitCnt <= '0;
            ctlTaint <= 1'b0;
        end else begin
            state <= nextState;
            case (state)
                START: begin
                    if (start) begin
                        ctlTaint <= startTaint;
                    end
                end
                INIT: bitCnt <= '0;
                SHIFT: begin
                    bitCnt <= bitCnt + 1'b1;
                    // Branch on a tainted word taints everything after it
                    ctlTaint <= ctlTaint | ctl.multiplierTaint;
                end
                FINAL: ctlTaint <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

/* verilog/multiplierDatapath.sv */
/*
 * Operand registers, shift-add accumulator with taint, and output register.
 * Strobes come from multiplierControl through mulCtrlIf.
 */

`include "taint_mul_defines.svh"

module multiplierDatapath (
    input  logic clk,
    input  logic rst,
    input  logic [`MUL_WIDTH-1:0] multiplicand,
    input  logic [`MUL_WIDTH-1:0] multiplier,
    input  logic multiplicandTaint,
    input  logic multiplierTaint,
    input  logic outReady,
    output logic outValid,
    output logic resultPending,
    output logic [2*`MUL_WIDTH-1:0] product,
    output logic productTaint,
    mulCtrlIf.dp ctl
);

    logic [`MUL_WIDTH-1:0] mdReg;
    logic mdTaint;
    logic [`MUL_WIDTH-1:0] mrReg;
    logic mrTaint;
    logic [2*`MUL_WIDTH-1:0] resultReg;
    // Add carry, shifted into the top bit on the next shift
    logic resultCarry;
    logic resultTaint;
    logic resultTaintNext;
    logic [`MUL_WIDTH:0] upperSum;
    logic [2*`MUL_WIDTH-1:0] shiftedResult;

    assign upperSum = {1'b0, resultReg[2*`MUL_WIDTH-1:`MUL_WIDTH]} + {1'b0, mdReg};
    assign shiftedResult = {resultCarry, resultReg[2*`MUL_WIDTH-1:1]};

    assign ctl.multiplier = mrReg;
    assign ctl.multiplierTaint = mrTaint;

    // ====================
    // Operands
    // ====================

    always_ff @(posedge clk) begin
        if (ctl.mdLoad) begin
            mdReg <= multiplicand;
        end
        if (ctl.mrLoad) begin
            mrReg <= multiplier;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mdTaint <= 1'b0;
            mrTaint <= 1'b0;
        end else begin
            if (ctl.mdLoad) begin
                mdTaint <= multiplicandTaint | ctl.mdLoadTaint;
            end
            if (ctl.mrLoad) begin
                mrTaint <= multiplierTaint | ctl.mrLoadTaint;
            end
        end
    end

    // ====================
    // Accumulator
    // ====================

    always_ff @(posedge clk) begin
        if (ctl.rsClear) begin
            resultReg <= '0;
            resultCarry <= 1'b0;
        end else if (ctl.rsLoad) begin
            resultReg <= {upperSum[`MUL_WIDTH-1:0], resultReg[`MUL_WIDTH-1:0]};
            resultCarry <= upperSum[`MUL_WIDTH];
        end else if (ctl.rsShr) begin
            resultReg <= shiftedResult;
            resultCarry <= 1'b0;
        end
    end

    // A tainted strobe taints the result even when it does not fire
    always_comb begin
        resultTaintNext = ctl.rsClear ? 1'b0 : resultTaint;
        resultTaintNext = resultTaintNext | ctl.rsClearTaint | ctl.rsLoadTaint | ctl.rsShrTaint;
        if (ctl.rsLoad) begin
            resultTaintNext = resultTaintNext | mdTaint;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultTaint <= 1'b0;
        end else begin
            resultTaint <= resultTaintNext;
        end
    end

    // ====================
    // Output register
    // ====================

    assign resultPending = outValid;

    always_ff @(posedge clk) begin
        if (ctl.productDone) begin
            product <= shiftedResult;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            productTaint <= 1'b0;
        end else if (ctl.productDone) begin
            outValid <= 1'b1;
            productTaint <= resultTaintNext | ctl.productDoneTaint;
        end else if (outValid && outReady) begin
            outValid <= 1'b0;
        end
    end

endmodule

/* verilog/taintMultiplier.sv */
/*
 * Top level of the taint-tracking multiplier with valid/ready ports.
 * One multiplication in flight, product held until outReady.
 */

`include "taint_mul_defines.svh"

module taintMultiplier (
    input  logic clk,
    input  logic rst,
    // Operand side
    input  logic inValid,
    output logic inReady,
    input  logic [`MUL_WIDTH-1:0] multiplicand,
    input  logic [`MUL_WIDTH-1:0] multiplier,
    input  logic multiplicandTaint,
    input  logic multiplierTaint,
    input  logic startTaint,
    // Product side
    output logic outValid,
    input  logic outReady,
    output logic [2*`MUL_WIDTH-1:0] product,
    output logic productTaint
);

    logic accept;
    logic resultPending;

    mulCtrlIf ctlBus ();

    // Input transfer starts a job
    assign accept = inValid & inReady;

    multiplierControl i_multiplierControl (
        .clk(clk),
        .rst(rst),
        .start(accept),
        .startTaint(startTaint),
        .resultPending(resultPending),
        .inReady(inReady),
        .ctl(ctlBus.ctrl)
    );

    multiplierDatapath i_multiplierDatapath (
        .clk(clk),
        .rst(rst),
        .multiplicand(multiplicand),
        .multiplier(multiplier),
        .multiplicandTaint(multiplicandTaint),
        .multiplierTaint(multiplierTaint),
        .outReady(outReady),
        .outValid(outValid),
        .resultPending(resultPending),
        .product(product),
        .productTaint(productTaint),
        .ctl(ctlBus.dp)
    );

endmodule

/* verif/taintMultiplierChecker.sv */
/*
 * Handshake and reset assertions for the taint multiplier, attached by bind.
 */

`include "taint_mul_defines.svh"

module taintMultiplierChecker
    import taintMulPkg::*;
(
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic inReady,
    input logic [`MUL_WIDTH-1:0] multiplicand,
    input logic [`MUL_WIDTH-1:0] multiplier,
    input logic multiplicandTaint,
    input logic multiplierTaint,
    input logic startTaint,
    input logic outValid,
    input logic outReady,
    input logic [2*`MUL_WIDTH-1:0] product,
    input logic productTaint,
    input ctrlState state
);
    timeunit 1ns;
    timeprecision 1ps;

    // Open from the accepting edge until the output transfer
    logic jobOpen;
    // Failed assertions so far
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            jobOpen <= 1'b0;
        end else if (inValid && inReady) begin
            jobOpen <= 1'b1;
        end else if (outValid && outReady) begin
            jobOpen <= 1'b0;
        end
    end

    // Offered operands held until accepted
    inputHold: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable(multiplicand) && $stable(multiplier)
            && $stable(multiplicandTaint) && $stable(multiplierTaint) && $stable(startTaint))
        else begin
            $error("Operands changed while waiting for inReady");
            failCount++;
        end

    outputHold: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(product) && $stable(productTaint))
        else begin
            $error("Product changed while waiting for outReady");
            failCount++;
        end

    // Reset leaves the FSM idle with no result
    resetIdle: assert property (@(posedge clk) rst |=> !outValid && state == START)
        else begin
            $error("Output valid or FSM not idle after reset");
            failCount++;
        end

    oneInFlight: assert property (@(posedge clk) disable iff (rst)
        !(inReady && (jobOpen || outValid)))
        else begin
            $error("inReady high while a job is in flight");
            failCount++;
        end

endmodule

/* verif/taintMultiplierTb.sv */
/*
 * Testbench for the taint multiplier, stimulus from verif/mul_patterns.txt.
 * Checks product, taint, latency and handshakes under random output stalls.
 */

`include "taint_mul_defines.svh"

module taintMultiplierTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 2 * `MUL_WIDTH + 2;
    // Stall length is masked with this, so keep it one less than a power of two
    localparam int MAX_STALL = 7;
    localparam int RESET_CYCLES = 5;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    logic [`MUL_WIDTH-1:0] multiplicand;
    logic [`MUL_WIDTH-1:0] multiplier;
    logic multiplicandTaint;
    logic multiplierTaint;
    logic startTaint;
    logic outValid;
    logic outReady;
    logic [2*`MUL_WIDTH-1:0] product;
    logic productTaint;

    int seed;
    int cycleCount;
    int cycleLimit;
    int resultCount;
    logic [`MUL_WIDTH-1:0] mdQ[$];
    logic [`MUL_WIDTH-1:0] mrQ[$];
    logic [2:0] taintQ[$];
    logic [2*`MUL_WIDTH-1:0] prodQ[$];
    logic prodTaintQ[$];

    taintMultiplier i_taintMultiplier (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .multiplicand(multiplicand),
        .multiplier(multiplier),
        .multiplicandTaint(multiplicandTaint),
        .multiplierTaint(multiplierTaint),
        .startTaint(startTaint),
        .outValid(outValid),
        .outReady(outReady),
        .product(product),
        .productTaint(productTaint)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $fatal(1, "Cycle limit reached");
        end
    end

    // Output transfers seen on the DUT ports
    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            resultCount <= resultCount + 1;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic readPatterns();
        int fd;
        int fields;
        string line;
        logic [`MUL_WIDTH-1:0] md;
        logic [`MUL_WIDTH-1:0] mr;
        logic mdT;
        logic mrT;
        logic stT;
        logic [2*`MUL_WIDTH-1:0] prod;
        logic prodT;
        fd = $fopen("verif/mul_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/mul_patterns.txt");
            $display("STATUS: FAIL");
            $fatal(1, "Missing pattern file");
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comment and blank lines
            if (line.len() > 1 && line.getc(0) != "/") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                 md, mr, mdT, mrT, stT, prod, prodT);
                if (fields != 7) begin
                    $display("Malformed line in the pattern file: %s", line);
                    $display("STATUS: FAIL");
                    $fatal(1, "Bad pattern line");
                end
                mdQ.push_back(md);
                mrQ.push_back(mr);
                taintQ.push_back({mdT, mrT, stT});
                prodQ.push_back(prod);
                prodTaintQ.push_back(prodT);
            end
        end
        $fclose(fd);
    endtask

    task automatic offerOperands(input int idx);
        inValid = 1'b1;
        multiplicand = mdQ[idx];
        multiplier = mrQ[idx];
        {multiplicandTaint, multiplierTaint, startTaint} = taintQ[idx];
    endtask

    task automatic runPattern(input int idx);
        int acceptCycle;
        int stallLen;
        int waited;
        int rnd;
        logic transferred;
        offerOperands(idx);
        while (!inReady) begin
            @(negedge clk);
        end
        // Accepting edge has passed, scramble inputs to prove they were captured
        @(negedge clk);
        acceptCycle = cycleCount;
        inValid = 1'b0;
        rnd = $random(seed);
        multiplicand = rnd[`MUL_WIDTH-1:0];
        multiplier = rnd[2*`MUL_WIDTH-1:`MUL_WIDTH];
        {multiplicandTaint, multiplierTaint, startTaint} = rnd[18:16];
        while (!outValid) begin
            compareValue("inReady", inReady, 0);
            @(negedge clk);
        end
        compareValue("latency", cycleCount - acceptCycle, LATENCY);
        rnd = $random(seed);
        stallLen = rnd & MAX_STALL;
        waited = 0;
        transferred = 1'b0;
        while (!transferred) begin
            compareValue("outValid", outValid, 1);
            compareValue("product", product, prodQ[idx]);
            compareValue("productTaint", productTaint, prodTaintQ[idx]);
            compareValue("inReady", inReady, 0);
            // Next job waits on inReady while this result is pending
            if (idx + 1 < mdQ.size()) begin
                offerOperands(idx + 1);
            end
            outReady = (waited >= stallLen);
            transferred = outReady;
            waited++;
            @(negedge clk);
        end
        outReady = 1'b0;
        compareValue("outValid", outValid, 0);
        compareValue("inReady", inReady, 1);
    endtask

    initial begin
        seed = 28264;
        cycleCount = 0;
        cycleLimit = 0;
        resultCount = 0;
        rst = 1'b1;
        inValid = 1'b0;
        multiplicand = '0;
        multiplier = '0;
        multiplicandTaint = 1'b0;
        multiplierTaint = 1'b0;
        startTaint = 1'b0;
        outReady = 1'b0;
        readPatterns();
        cycleLimit = RESET_CYCLES + mdQ.size() * (LATENCY + MAX_STALL + 4);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compareValue("outValid", outValid, 0);
        compareValue("inReady", inReady, 1);
        for (int i = 0; i < mdQ.size(); i++) begin
            runPattern(i);
        end
        compareValue("resultCount", resultCount, mdQ.size());
        if (i_taintMultiplier.i_taintMultiplierChecker.failCount == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed during the run");
            $display("STATUS: FAIL");
            $fatal(1, "Checker assertions failed");
        end
    end

endmodule

// Protocol checker inside the DUT, sees the FSM state directly
bind taintMultiplier taintMultiplierChecker i_taintMultiplierChecker (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .multiplicand(multiplicand),
    .multiplier(multiplier),
    .multiplicandTaint(multiplicandTaint),
    .multiplierTaint(multiplierTaint),
    .startTaint(startTaint),
    .outValid(outValid),
    .outReady(outReady),
    .product(product),
    .productTaint(productTaint),
    .state(i_multiplierControl.state)
);

/* verif/mul_patterns.txt */
// multiplicand multiplier mdTaint mrTaint startTaint product productTaint
// All hex, product taint = start | mr | (md & multiplier nonzero)
00 00 0 0 0 0000 0
01 01 0 0 0 0001 0
ff ff 0 0 0 fe01 0
0c 0d 0 0 0 009c 0
a5 00 1 0 0 0000 0
a5 03 1 0 0 01ef 1
07 80 1 0 0 0380 1
00 00 0 1 0 0000 1
3c 5a 0 1 0 1518 1
00 00 0 0 1 0000 1
12 34 0 0 1 03a8 1
12 34 0 0 0 03a8 0
80 ff 1 1 1 7f80 1
c8 64 0 0 0 4e20 0

/* sources.f */
+incdir+include
verilog/taintMulPkg.sv
verilog/mulCtrlIf.sv
verilog/multiplierControl.sv
verilog/multiplierDatapath.sv
verilog/taintMultiplier.sv
verif/taintMultiplierChecker.sv
verif/taintMultiplierTb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module taintMultiplierTb \
    -f sources.f -o simv && ./obj_dir/simv || exit 1
